/* hdl/ifu_cfg.svh */
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// address of the first fetch after reset
`define IFU_RESET_PC 32'h3000_0000

// bytes per instruction, no compressed encodings
`define IFU_INST_STEP 4

// width of the read address bus and of the pc
`define IFU_ADDR_W 32

`endif

/* hdl/ifu_pkg.sv */
`include "ifu_cfg.svh"

package ifu_pkg;

	// fetch address and pc
	typedef logic [`IFU_ADDR_W-1:0] addr_t;

	// one uncompressed instruction word
	typedef logic [31:0] inst_t;

	// read response codes of the bus
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	// fetch sequencing
	// S_ADDR drives the address, S_DATA waits for the word
	// and S_HOLD offers it to decode
	typedef enum logic [1:0] {
		S_ADDR = 2'b00,
		S_DATA = 2'b01,
		S_HOLD = 2'b10
	} fetch_state_t;

endpackage

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl import ifu_pkg::*; (
	input  logic clk,
	input  logic rst,

	// one-cycle redirect request from execute
	input  logic flush,

	// bus handshakes
	input  logic arready,
	input  logic rvalid,

	// decode handshake
	input  logic inst_ready,

	output logic arvalid,
	output logic rready,
	output logic inst_valid,

	// strobes for the datapath
	output logic target_capture,
	output logic pc_step,
	output logic pc_load_now,
	output logic pc_load_latched,
	output logic word_capture
);

	fetch_state_t state;
	fetch_state_t state_next;

	// a flush seen while a read was in flight
	logic flush_pend;

	logic in_addr;
	logic in_data;
	logic in_hold;

	logic addr_done;
	logic data_done;
	logic hold_done;
	logic redirect;

	// state decode
	assign in_addr = (state == S_ADDR);
	assign in_data = (state == S_DATA);
	assign in_hold = (state == S_HOLD);

	// bus levels follow the state directly
	assign arvalid = in_addr;
	assign rready  = in_data;

	// word is held back from decode once any flush is known
	// the live flush term is combinational on purpose
	assign inst_valid = in_hold && !flush_pend && !flush;

	// bus transfers
	assign addr_done = in_addr && arready;
	assign data_done = in_data && rvalid;

	// flush during a fetch only gets remembered
	assign target_capture = flush && (in_addr || in_data);

	// live flush has priority over the latched one
	assign pc_load_now     = in_hold && flush;
	assign pc_load_latched = in_hold && !flush && flush_pend;

	// normal advance on a decode transfer
	assign pc_step = inst_valid && inst_ready;

	assign redirect  = pc_load_now || pc_load_latched;
	assign hold_done = redirect || pc_step;

	// word register loads on the data transfer
	assign word_capture = data_done;

	always_comb begin
		state_next = state;
		case (state)
			S_ADDR: begin
				if (addr_done) begin
					state_next = S_DATA;
				end
			end
			S_DATA: begin
				if (data_done) begin
					state_next = S_HOLD;
				end
			end
			S_HOLD: begin
				// discarded words also go back for a new fetch
				if (hold_done) begin
					state_next = S_ADDR;
				end
			end
			default: begin
				state_next = S_ADDR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_ADDR;
		end else begin
			state <= state_next;
		end
	end

	// set on capture and cleared when the redirect is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			flush_pend <= 1'b0;
		end else if (target_capture) begin
			flush_pend <= 1'b1;
		end else if (redirect) begin
			flush_pend <= 1'b0;
		end
	end

endmodule

/* hdl/pc_gen.sv */
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module pc_gen import ifu_pkg::*; (
	input  logic  clk,
	input  logic  rst,

	// redirect address from execute
	input  addr_t flush_target,

	// strobes from the control FSM
	input  logic  target_capture,
	input  logic  pc_step,
	input  logic  pc_load_now,
	input  logic  pc_load_latched,

	// current fetch address
	output addr_t pc
);

	localparam addr_t RESET_PC  = addr_t'(`IFU_RESET_PC);
	localparam addr_t INST_STEP = addr_t'(`IFU_INST_STEP);

	// target saved from a flush during an in-flight fetch
	addr_t target_latch;

	addr_t pc_seq;
	addr_t pc_next;

	// sequential successor
	assign pc_seq = pc + INST_STEP;

	// strobes are exclusive so the order only matters for clarity
	always_comb begin
		pc_next = pc;
		if (pc_load_now) begin
			pc_next = flush_target;
		end else if (pc_load_latched) begin
			pc_next = target_latch;
		end else if (pc_step) begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// later flushes overwrite the saved target
	always_ff @(posedge clk) begin
		if (target_capture) begin
			target_latch <= flush_target;
		end
	end

endmodule

/* hdl/inst_latch.sv */
`timescale 1ns/1ps

module inst_latch import ifu_pkg::*; (
	input  logic  clk,
	input  logic  rst,

	// load strobe on the read data transfer
	input  logic  word_capture,

	// read data channel
	input  inst_t rdata,
	input  resp_t rresp,

	// towards decode
	output inst_t inst,
	output logic  inst_err
);

	logic resp_bad;

	// exclusive okay counts as success
	assign resp_bad = (rresp == RESP_SLVERR) || (rresp == RESP_DECERR);

	// word and error level stay put until the next read returns
	always_ff @(posedge clk) begin
		if (rst) begin
			inst     <= '0;
			inst_err <= 1'b0;
		end else if (word_capture) begin
			inst     <= rdata;
			inst_err <= resp_bad;
		end
	end

endmodule

/* hdl/ifu.sv */
`timescale 1ns/1ps

module ifu import ifu_pkg::*; (
	input  logic  clk,
	input  logic  rst,

	// redirect from execute
	input  logic  flush,
	input  addr_t flush_target,

	// read address channel
	output addr_t araddr,
	output logic  arvalid,
	input  logic  arready,

	// read data channel
	input  inst_t rdata,
	input  resp_t rresp,
	input  logic  rvalid,
	output logic  rready,

	// decode channel
	output inst_t inst,
	output logic  inst_err,
	output addr_t inst_pc,
	output logic  inst_valid,
	input  logic  inst_ready
);

	// control to datapath strobes
	logic target_capture;
	logic pc_step;
	logic pc_load_now;
	logic pc_load_latched;
	logic word_capture;

	addr_t pc;

	// the held word always belongs to the address that fetched it
	assign araddr  = pc;
	assign inst_pc = pc;

	fetch_ctrl i_ctrl (
		.clk             (clk),
		.rst             (rst),
		.flush           (flush),
		.arready         (arready),
		.rvalid          (rvalid),
		.inst_ready      (inst_ready),
		.arvalid         (arvalid),
		.rready          (rready),
		.inst_valid      (inst_valid),
		.target_capture  (target_capture),
		.pc_step         (pc_step),
		.pc_load_now     (pc_load_now),
		.pc_load_latched (pc_load_latched),
		.word_capture    (word_capture)
	);

	pc_gen i_pc (
		.clk             (clk),
		.rst             (rst),
		.flush_target    (flush_target),
		.target_capture  (target_capture),
		.pc_step         (pc_step),
		.pc_load_now     (pc_load_now),
		.pc_load_latched (pc_load_latched),
		.pc              (pc)
	);

	inst_latch i_word (
		.clk          (clk),
		.rst          (rst),
		.word_capture (word_capture),
		.rdata        (rdata),
		.rresp        (rresp),
		.inst         (inst),
		.inst_err     (inst_err)
	);

endmodule

/* bench/ifu_checker.sv */
`timescale 1ns/1ps

module ifu_checker import ifu_pkg::*; (
	input logic         clk,
	input logic         rst,
	input logic         flush,
	input logic         arready,
	input logic         arvalid,
	input logic         rready,
	input logic         inst_valid,
	input logic         pc_step,
	input logic         pc_load_now,
	input logic         pc_load_latched,
	input fetch_state_t state
);

	// number of failed assertions, polled by the testbench
	int fail_count = 0;

	// address stays offered until the slave takes it
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && (state == S_ADDR))
		else begin
			fail_count++;
			$error("arvalid dropped before arready");
		end

	// one item in flight, so at most one channel is active
	one_channel: assert property (@(posedge clk) disable iff (rst)
		$onehot0({arvalid, rready, inst_valid}))
		else begin
			fail_count++;
			$error("more than one of arvalid, rready and inst_valid high");
		end

	pc_strobes: assert property (@(posedge clk) disable iff (rst)
		$onehot0({pc_step, pc_load_now, pc_load_latched}))
		else begin
			fail_count++;
			$error("several pc update strobes high in one cycle");
		end

	// live flush hides the held word
	flush_blocks: assert property (@(posedge clk) disable iff (rst)
		flush |-> !inst_valid)
		else begin
			fail_count++;
			$error("inst_valid high during a flush");
		end

endmodule

bind fetch_ctrl ifu_checker i_checker (
	.clk             (clk),
	.rst             (rst),
	.flush           (flush),
	.arready         (arready),
	.arvalid         (arvalid),
	.rready          (rready),
	.inst_valid      (inst_valid),
	.pc_step         (pc_step),
	.pc_load_now     (pc_load_now),
	.pc_load_latched (pc_load_latched),
	.state           (state)
);

/* bench/ifu_tb.sv */
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_tb import ifu_pkg::*; ();

	localparam int NUM_INST     = 2000;
	localparam int RESET_CYCLES = 5;
	localparam int RESET_WAIT   = 20;
	localparam int INST_WAIT    = 400;

	logic  clk = 1'b0;
	logic  rst;
	logic  flush;
	addr_t flush_target;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	inst_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;
	inst_t inst;
	logic  inst_err;
	addr_t inst_pc;
	logic  inst_valid;
	logic  inst_ready;

	integer seed;

	// reference model
	fetch_state_t m_state;
	addr_t        m_pc;
	addr_t        m_target;
	logic         m_discard;
	inst_t        m_word;
	logic         m_err;

	// bus slave with one outstanding read
	logic  rd_busy;
	addr_t rd_addr;
	logic  rd_bad;

	int   accepted;
	int   wait_cycles;
	logic done_xfer;

	always begin
		#5 clk = ~clk;
	end

	ifu i_dut (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.flush_target (flush_target),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.inst         (inst),
		.inst_err     (inst_err),
		.inst_pc      (inst_pc),
		.inst_valid   (inst_valid),
		.inst_ready   (inst_ready)
	);

	// word the slave returns for an address
	function automatic inst_t word_hash(input addr_t a);
		inst_t h;
		h = a ^ 32'h9e37_79b9;
		h = {h[12:0], h[31:13]} + (a >> 7);
		return h;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_inst(input string what, input inst_t got, input inst_t exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_err(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// one clock: compare, advance the model, then drive the next inputs
	task automatic step_cycle(output logic xfer);
		logic exp_arvalid;
		logic exp_rready;
		logic exp_ivalid;
		logic addr_xfer;
		logic data_xfer;
		int   roll;
		int   jump;

		@(posedge clk);
		xfer = 1'b0;
		if (i_dut.i_ctrl.i_checker.fail_count != 0) begin
			report_failure("a protocol assertion in the checker failed");
		end

		exp_arvalid = (m_state == S_ADDR);
		exp_rready  = (m_state == S_DATA);
		exp_ivalid  = (m_state == S_HOLD) && !m_discard && !flush;
		check_flag("arvalid", arvalid, exp_arvalid);
		check_flag("rready", rready, exp_rready);
		check_flag("inst_valid", inst_valid, exp_ivalid);
		if (exp_arvalid) begin
			check_addr("araddr", araddr, m_pc);
		end
		// held word checked every cycle, so stalls must keep it stable
		if (exp_ivalid) begin
			check_addr("inst_pc", inst_pc, m_pc);
			check_inst("inst", inst, m_word);
			check_err("inst_err", inst_err, m_err);
		end

		addr_xfer = exp_arvalid && arready;
		data_xfer = exp_rready && rvalid;

		case (m_state)
			S_ADDR, S_DATA: begin
				// word in flight gets dropped later
				if (flush) begin
					m_discard = 1'b1;
					m_target  = flush_target;
				end
				if (addr_xfer) begin
					m_state = S_DATA;
				end
				if (data_xfer) begin
					m_state = S_HOLD;
					m_word  = word_hash(m_pc);
					m_err   = rd_bad;
				end
			end
			S_HOLD: begin
				if (flush) begin
					m_pc      = flush_target;
					m_discard = 1'b0;
					m_state   = S_ADDR;
				end else if (m_discard) begin
					m_pc      = m_target;
					m_discard = 1'b0;
					m_state   = S_ADDR;
				end else if (inst_ready) begin
					m_pc    = m_pc + addr_t'(`IFU_INST_STEP);
					m_state = S_ADDR;
					xfer    = 1'b1;
				end
			end
			default: begin
				report_failure("reference model reached an unknown state");
			end
		endcase

		if (data_xfer) begin
			rd_busy = 1'b0;
		end
		if (addr_xfer) begin
			rd_busy = 1'b1;
			rd_addr = araddr;
		end

		roll = $random(seed);
		jump = $random(seed);

		// read data is held once offered
		if (!rvalid || data_xfer) begin
			if (rd_busy && roll[5:4] != 2'b00) begin
				rd_bad = (roll[2:0] == 3'd0);
				rvalid <= 1'b1;
				rdata  <= word_hash(rd_addr);
				if (rd_bad) begin
					rresp <= roll[3] ? RESP_DECERR : RESP_SLVERR;
				end else begin
					rresp <= roll[3] ? RESP_EXOKAY : RESP_OKAY;
				end
			end else begin
				rvalid <= 1'b0;
				rdata  <= $random(seed);
				rresp  <= roll[9] ? RESP_SLVERR : RESP_OKAY;
			end
		end

		arready      <= roll[6];
		inst_ready   <= (roll[8:7] != 2'b00);
		flush        <= !flush && (roll[13:10] == 4'd0);
		flush_target <= addr_t'({jump[31:2], 2'b00});
	endtask

	initial begin
		seed         = 32'he7e8a58e;
		rst          = 1'b1;
		flush        = 1'b0;
		flush_target = '0;
		arready      = 1'b0;
		rdata        = '0;
		rresp        = RESP_OKAY;
		rvalid       = 1'b0;
		inst_ready   = 1'b0;

		m_state   = S_ADDR;
		m_pc      = `IFU_RESET_PC;
		m_target  = '0;
		m_discard = 1'b0;
		m_word    = '0;
		m_err     = 1'b0;
		rd_busy   = 1'b0;
		rd_addr   = '0;
		rd_bad    = 1'b0;
		accepted  = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		wait_cycles = 0;
		while (rst || arvalid !== 1'b1) begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > RESET_WAIT) begin
				report_failure("timeout: no read address was offered after reset");
			end
		end
		check_addr("first araddr", araddr, addr_t'(`IFU_RESET_PC));

		while (accepted < NUM_INST) begin
			wait_cycles = 0;
			done_xfer   = 1'b0;
			while (!done_xfer) begin
				step_cycle(done_xfer);
				wait_cycles++;
				if (!done_xfer && wait_cycles > INST_WAIT) begin
					report_failure($sformatf(
						"timeout: instruction %0d was never accepted by decode", accepted));
				end
			end
			accepted++;
		end

		// assertions on the last edge settle before the half cycle is over
		@(negedge clk);
		if (i_dut.i_ctrl.i_checker.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("a protocol assertion in the checker failed");
		end
	end

endmodule

/* ifu.f */
+incdir+hdl
hdl/ifu_pkg.sv
hdl/fetch_ctrl.sv
hdl/pc_gen.sv
hdl/inst_latch.sv
hdl/ifu.sv
bench/ifu_checker.sv
bench/ifu_tb.sv

/* Makefile */
# Verilator flow for the instruction fetch unit

TOOL       := verilator
TOP        := ifu_tb
FILELIST   := ifu.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Verification failed
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run may stop early, so its exit status is not used and the log decides
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported an error, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
